/* icache_pkg.sv */
// instruction cache shared types for address fields, cache lines and controller states
`default_nettype none

package icache_pkg;

    // address field widths
    localparam int ADDR_W     = 32;
    localparam int TAG_W      = 20;
    localparam int SET_W      = 6;
    localparam int WORD_SEL_W = 4;
    localparam int WORD_W     = 32;

    // line geometry and l1 depth
    localparam int LINE_WORDS = 16;
    localparam int L1_SETS    = 1 << SET_W;

    typedef logic [ADDR_W-1:0]       addr_t;
    typedef logic [TAG_W-1:0]        tag_t;
    typedef logic [SET_W-1:0]        set_index_t;
    // tag above index, also the memory line address
    typedef logic [TAG_W+SET_W-1:0]  line_tag_t;
    typedef logic [WORD_SEL_W-1:0]   word_sel_t;
    typedef logic [WORD_W-1:0]       word_t;
    // word 0 sits in the low 32 bits
    typedef word_t [LINE_WORDS-1:0]  line_t;

    // a line moving between the l1 and the victim buffer
    typedef struct packed {
        line_tag_t tag;
        line_t     line;
    } evict_line_t;

    // fetch controller states
    typedef enum logic [2:0] {
        IDLE,
        CHECK,
        SWAP,
        MEM_REQ,
        MEM_DROP,
        RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire

/* icache_l1_array.sv */
// direct-mapped l1 instruction store with combinational lookup and registered line fill
`timescale 1ns/1ps
`default_nettype none

module icache_l1_array
    import icache_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire line_tag_t   line_tag,
    input  wire logic        fill_we,
    input  wire line_t       fill_line,
    output      logic        l1_hit,
    output      line_t       l1_line,
    output      evict_line_t l1_occupant,
    output      logic        l1_occupant_valid
);

    // per-set valid bits, cleared by reset
    logic [L1_SETS-1:0] valid;

    // tag and data arrays
    tag_t  tag_mem  [L1_SETS];
    line_t line_mem [L1_SETS];

    set_index_t set_idx;
    tag_t       req_tag;

    // split the line tag into tag and set index
    assign set_idx = line_tag[SET_W-1:0];
    assign req_tag = line_tag[TAG_W+SET_W-1:SET_W];

    // lookup
    assign l1_hit  = valid[set_idx] && (tag_mem[set_idx] == req_tag);
    assign l1_line = line_mem[set_idx];

    // current occupant of the set, rebuilt as a full line tag for eviction
    assign l1_occupant.tag    = {tag_mem[set_idx], set_idx};
    assign l1_occupant.line   = line_mem[set_idx];
    assign l1_occupant_valid  = valid[set_idx];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (fill_we) begin
            valid[set_idx] <= 1'b1;
        end
    end

    // fill replaces tag and line of the addressed set
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[set_idx]  <= req_tag;
            line_mem[set_idx] <= fill_line;
        end
    end

    // the controller leaves its fill state right after the write
    a_fill_single_cycle: assert property (
        @(posedge clk) disable iff (!rstn)
        fill_we |=> !fill_we
    ) else $error("l1 fill write held for more than one cycle");

endmodule

`default_nettype wire

/* victim_icache.sv */
// fully associative victim line buffer with rotating replacement and invalidate on hit
`timescale 1ns/1ps
`default_nettype none

module victim_icache
    import icache_pkg::*;
#(
    parameter int VICTIM_ENTRIES = 16
) (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire line_tag_t   r_tag,
    input  wire logic        vic_we,
    input  wire evict_line_t vic_wr,
    input  wire logic        vic_inv,
    output      logic        victim_hit,
    output      line_t       data_out
);

    localparam int CNT_W = $clog2(VICTIM_ENTRIES);

    typedef logic [CNT_W-1:0] slot_t;

    logic [VICTIM_ENTRIES-1:0] valid;
    line_tag_t                 tag_mem  [VICTIM_ENTRIES];
    line_t                     line_mem [VICTIM_ENTRIES];

    // replacement pointer, oldest write first
    slot_t counter;

    logic [VICTIM_ENTRIES-1:0] hit;
    slot_t                     hit_idx;

    // every entry compares against the lookup tag
    always_comb begin
        for (int i = 0; i < VICTIM_ENTRIES; i++) begin
            hit[i] = valid[i] && (tag_mem[i] == r_tag);
        end
    end

    // priority select, lowest hitting entry wins
    always_comb begin
        hit_idx = '0;
        for (int i = VICTIM_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                hit_idx = slot_t'(i);
            end
        end
    end

    assign victim_hit = |hit;
    assign data_out   = victim_hit ? line_mem[hit_idx] : '0;

    // valid bits and counter
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid   <= '0;
            counter <= '0;
        end else begin
            // invalidate first so a write to the same slot wins
            if (vic_inv) begin
                for (int i = 0; i < VICTIM_ENTRIES; i++) begin
                    if (hit[i]) begin
                        valid[i] <= 1'b0;
                    end
                end
            end
            if (vic_we) begin
                valid[counter] <= 1'b1;
                if (counter == slot_t'(VICTIM_ENTRIES - 1)) begin
                    counter <= '0;
                end else begin
                    counter <= counter + 1'b1;
                end
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (vic_we) begin
            tag_mem[counter]  <= vic_wr.tag;
            line_mem[counter] <= vic_wr.line;
        end
    end

    // a line lives in only one store, so duplicates never appear here
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rstn)
        $onehot0(hit)
    ) else $error("more than one victim entry matches the lookup tag");

endmodule

`default_nettype wire

/* icache_ctrl.sv */
// fetch controller for lookup, l1/victim swap, memory refill and word return
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
    import icache_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rstn,
    // fetch port
    input  wire logic        cpu_req,
    input  wire addr_t       cpu_addr,
    output      logic        cpu_ack,
    output      word_t       cpu_rdata,
    // memory port
    output      logic        mem_req,
    output      line_tag_t   mem_addr,
    input  wire logic        mem_ack,
    input  wire line_t       mem_rdata,
    // l1 array
    output      line_tag_t   line_tag,
    input  wire logic        l1_hit,
    input  wire line_t       l1_line,
    input  wire evict_line_t l1_occupant,
    input  wire logic        l1_occupant_valid,
    output      logic        fill_we,
    output      line_t       fill_line,
    // victim buffer
    input  wire logic        victim_hit,
    input  wire line_t       victim_line,
    output      logic        vic_we,
    output      evict_line_t vic_wr,
    output      logic        vic_inv
);

    ctrl_state_t state;

    // captured fetch address and refill line
    addr_t     addr_q;
    line_t     refill_q;
    word_sel_t word_sel;

    logic  start;
    logic  load_rdata;
    line_t resp_line;

    assign start    = (state == IDLE) && cpu_req && !cpu_ack;
    assign line_tag = addr_q[ADDR_W-1:ADDR_W-TAG_W-SET_W];
    assign word_sel = addr_q[WORD_SEL_W+1:2];
    assign mem_addr = line_tag;

    // l1 write on swap or once the memory handshake has closed
    assign fill_we   = (state == SWAP) || ((state == MEM_DROP) && !mem_ack);
    assign fill_line = (state == SWAP) ? victim_line : refill_q;

    // displaced l1 line moves into the victim buffer in the same cycle
    assign vic_we  = fill_we && l1_occupant_valid;
    assign vic_wr  = l1_occupant;
    assign vic_inv = (state == SWAP);

    // where the returned word comes from
    assign load_rdata = ((state == CHECK) && l1_hit) || fill_we;

    always_comb begin
        case (state)
            CHECK:   resp_line = l1_line;
            SWAP:    resp_line = victim_line;
            default: resp_line = refill_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= IDLE;
            cpu_ack <= 1'b0;
            mem_req <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= CHECK;
                    end
                end
                CHECK: begin
                    // l1 first, then victim, else go to memory
                    if (l1_hit) begin
                        state <= RESPOND;
                    end else if (victim_hit) begin
                        state <= SWAP;
                    end else begin
                        mem_req <= 1'b1;
                        state   <= MEM_REQ;
                    end
                end
                SWAP: begin
                    state <= RESPOND;
                end
                MEM_REQ: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= MEM_DROP;
                    end
                end
                MEM_DROP: begin
                    // wait for ack low before touching the stores
                    if (!mem_ack) begin
                        state <= RESPOND;
                    end
                end
                RESPOND: begin
                    if (!cpu_ack) begin
                        cpu_ack <= 1'b1;
                    end else if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // address, refill line and returned word
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= cpu_addr;
        end
        if ((state == MEM_REQ) && mem_ack) begin
            refill_q <= mem_rdata;
        end
        if (load_rdata) begin
            cpu_rdata <= resp_line[word_sel];
        end
    end

    a_ack_needs_req: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(cpu_ack) |-> cpu_req
    ) else $error("cpu_ack rose while cpu_req was low");

    a_mem_req_held: assert property (
        @(posedge clk) disable iff (!rstn)
        $fell(mem_req) |-> $past(mem_ack)
    ) else $error("mem_req dropped before mem_ack was seen high");

endmodule

`default_nettype wire

/* icache_top.sv */
// instruction cache top level joining the fetch controller, l1 array and victim buffer
`timescale 1ns/1ps
`default_nettype none

module icache_top
    import icache_pkg::*;
#(
    parameter int VICTIM_ENTRIES = 16
) (
    input  wire logic      clk,
    input  wire logic      rstn,
    input  wire logic      cpu_req,
    input  wire addr_t     cpu_addr,
    output      logic      cpu_ack,
    output      word_t     cpu_rdata,
    output      logic      mem_req,
    output      line_tag_t mem_addr,
    input  wire logic      mem_ack,
    input  wire line_t     mem_rdata
);

    // lookup key shared by both stores
    line_tag_t   line_tag;

    // l1 side
    logic        l1_hit;
    line_t       l1_line;
    evict_line_t l1_occupant;
    logic        l1_occupant_valid;
    logic        fill_we;
    line_t       fill_line;

    // victim side
    logic        victim_hit;
    line_t       victim_line;
    logic        vic_we;
    evict_line_t vic_wr;
    logic        vic_inv;

    icache_ctrl u_ctrl (
        .clk               (clk),
        .rstn              (rstn),
        .cpu_req           (cpu_req),
        .cpu_addr          (cpu_addr),
        .cpu_ack           (cpu_ack),
        .cpu_rdata         (cpu_rdata),
        .mem_req           (mem_req),
        .mem_addr          (mem_addr),
        .mem_ack           (mem_ack),
        .mem_rdata         (mem_rdata),
        .line_tag          (line_tag),
        .l1_hit            (l1_hit),
        .l1_line           (l1_line),
        .l1_occupant       (l1_occupant),
        .l1_occupant_valid (l1_occupant_valid),
        .fill_we           (fill_we),
        .fill_line         (fill_line),
        .victim_hit        (victim_hit),
        .victim_line       (victim_line),
        .vic_we            (vic_we),
        .vic_wr            (vic_wr),
        .vic_inv           (vic_inv)
    );

    icache_l1_array u_l1 (
        .clk               (clk),
        .rstn              (rstn),
        .line_tag          (line_tag),
        .fill_we           (fill_we),
        .fill_line         (fill_line),
        .l1_hit            (l1_hit),
        .l1_line           (l1_line),
        .l1_occupant       (l1_occupant),
        .l1_occupant_valid (l1_occupant_valid)
    );

    victim_icache #(
        .VICTIM_ENTRIES (VICTIM_ENTRIES)
    ) u_victim (
        .clk        (clk),
        .rstn       (rstn),
        .r_tag      (line_tag),
        .vic_we     (vic_we),
        .vic_wr     (vic_wr),
        .vic_inv    (vic_inv),
        .victim_hit (victim_hit),
        .data_out   (victim_line)
    );

endmodule

`default_nettype wire

/* tb_icache_mem.sv */
// behavioral line memory answering four-phase line requests after a random delay
`timescale 1ns/1ps
`default_nettype none

module tb_icache_mem
    import icache_pkg::*;
#(
    parameter word_t KEY = 32'h0
) (
    input  wire logic      clk,
    input  wire logic      rstn,
    input  wire logic      mem_req,
    input  wire line_tag_t mem_addr,
    output      logic      mem_ack,
    output      line_t     mem_rdata
);

    integer seed = 32'h9d24;
    int     delay;

    // word w of a line is its byte address plus 4w, scrambled by the key
    function automatic line_t line_data(line_tag_t lt);
        line_t l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w] = ({lt, 6'b0} + word_t'(4 * w)) ^ KEY;
        end
        return l;
    endfunction

    initial begin
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            if (!rstn) begin
                mem_ack <= 1'b0;
            end else if (mem_req && !mem_ack) begin
                delay = 1 + ({$random(seed)} % 6);
                repeat (delay - 1) @(posedge clk);
                mem_rdata <= line_data(mem_addr);
                mem_ack   <= 1'b1;
                // ack stays up until the request is gone
                @(posedge clk);
                while (mem_req) begin
                    @(posedge clk);
                end
                mem_ack <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_icache.sv */
// testbench for the instruction cache with victim buffer, checked by assertions
`timescale 1ns/1ps
`default_nettype none

module tb_icache
    import icache_pkg::*;
();

    localparam word_t KEY        = 32'h5a3c_96e1;
    localparam int    VIC_N      = 16;
    localparam int    N_FETCH    = 73;
    // worst miss is roughly 18 cycles including hold, doubled for margin
    localparam int    WORST_MISS = 24;
    localparam int    MAX_CYCLES = N_FETCH * WORST_MISS * 2 + 40;

    logic      clk      = 1'b0;
    logic      rstn     = 1'b0;
    logic      cpu_req  = 1'b0;
    addr_t     cpu_addr = '0;
    logic      cpu_ack;
    word_t     cpu_rdata;
    logic      mem_req;
    line_tag_t mem_addr;
    logic      mem_ack;
    line_t     mem_rdata;

    // expectations for the fetch in flight
    word_t exp_word    = '0;
    int    exp_wait    = 0;
    logic  exp_miss    = 1'b0;
    int    wait_cnt    = 0;
    logic  miss_seen   = 1'b0;
    logic  mem_req_d   = 1'b0;
    int    mem_count   = 0;
    int    fetch_count = 0;
    int    err_count   = 0;
    int    cycles      = 0;
    // line address a miss must request, and misses so far
    line_tag_t exp_line      = '0;
    int        exp_mem_count = 0;

    // lines the testbench expects to be resident
    logic      l1_valid  [L1_SETS];
    line_tag_t l1_tag    [L1_SETS];
    logic      vic_valid [VIC_N];
    line_tag_t vic_tag   [VIC_N];
    int        vic_ptr;

    always #4 clk = ~clk;

    icache_top #(
        .VICTIM_ENTRIES (VIC_N)
    ) DUT (
        .clk       (clk),
        .rstn      (rstn),
        .cpu_req   (cpu_req),
        .cpu_addr  (cpu_addr),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    tb_icache_mem #(
        .KEY (KEY)
    ) u_mem (
        .clk       (clk),
        .rstn      (rstn),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    function automatic void report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
        err_count++;
        $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
    endfunction

    function automatic void report_protocol(string msg);
        err_count++;
        $display("%0t %s", $time, msg);
    endfunction

    function automatic addr_t make_addr(tag_t t, set_index_t s, word_sel_t w);
        return {t, s, w, 2'b00};
    endfunction

    // edges waited per fetch, memory requests seen, transaction count
    always @(posedge clk) begin
        cycles    <= cycles + 1;
        mem_req_d <= mem_req;
        if (mem_req && !mem_req_d) begin
            mem_count <= mem_count + 1;
        end
        if (cpu_req && !cpu_ack) begin
            wait_cnt <= wait_cnt + 1;
        end else begin
            wait_cnt <= 0;
        end
        if (!cpu_req) begin
            miss_seen <= 1'b0;
        end else if (mem_req) begin
            miss_seen <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped after %0d cycles before the fetch sequence ended", cycles);
            $display("errors: %0d, memory transactions: %0d", err_count, mem_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    a_rdata: assert property (@(posedge clk) disable iff (!rstn)
        cpu_ack |-> cpu_rdata == exp_word)
        else report_mismatch("cpu_rdata", $sampled(exp_word), $sampled(cpu_rdata));
    a_latency: assert property (@(posedge clk) disable iff (!rstn)
        $rose(cpu_ack) |-> (exp_wait == 0 || wait_cnt == exp_wait))
        else report_mismatch("cpu_ack wait", $sampled(exp_wait), $sampled(wait_cnt));
    a_miss: assert property (@(posedge clk) disable iff (!rstn)
        $rose(cpu_ack) |-> miss_seen == exp_miss)
        else report_mismatch("mem_req seen", $sampled(exp_miss), $sampled(miss_seen));
    a_reset_low: assert property (@(posedge clk)
        $rose(rstn) |-> !cpu_ack && !mem_req)
        else report_protocol("cpu_ack or mem_req was high right after reset");
    a_ack_after_req: assert property (@(posedge clk) disable iff (!rstn)
        $rose(cpu_ack) |-> cpu_req)
        else report_protocol("cpu_ack rose without a pending cpu_req");
    a_ack_fall: assert property (@(posedge clk) disable iff (!rstn)
        cpu_ack && !cpu_req |=> !cpu_ack)
        else report_protocol("cpu_ack stayed high after cpu_req dropped");
    a_ack_hold: assert property (@(posedge clk) disable iff (!rstn)
        cpu_ack && cpu_req |=> cpu_ack && $stable(cpu_rdata))
        else report_protocol("cpu_ack or cpu_rdata changed while cpu_req was held");
    a_mem_hold: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_ack |=> mem_req)
        else report_protocol("mem_req dropped before mem_ack arrived");
    a_mem_drop: assert property (@(posedge clk) disable iff (!rstn)
        mem_ack |=> !mem_req)
        else report_protocol("mem_req was high while mem_ack was still high");
    a_mem_addr: assert property (@(posedge clk) disable iff (!rstn)
        mem_req |=> !mem_req || $stable(mem_addr))
        else report_protocol("mem_addr changed while mem_req was high");
    a_mem_line: assert property (@(posedge clk) disable iff (!rstn)
        mem_req |-> mem_addr == exp_line)
        else report_mismatch("mem_addr", $sampled(exp_line), $sampled(mem_addr));

    task automatic clear_model();
        for (int i = 0; i < L1_SETS; i++) begin
            l1_valid[i] = 1'b0;
        end
        for (int i = 0; i < VIC_N; i++) begin
            vic_valid[i] = 1'b0;
        end
        vic_ptr = 0;
    endtask

    task automatic apply_reset();
        rstn <= 1'b0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        clear_model();
    endtask

    // one full four-phase fetch, holding cpu_req for extra cycles after ack
    task automatic fetch(input addr_t addr, input int hold);
        line_tag_t  lt;
        set_index_t s;
        int         found;
        lt    = addr[ADDR_W-1:6];
        s     = lt[SET_W-1:0];
        found = -1;
        if (l1_valid[s] && l1_tag[s] == lt) begin
            exp_wait = 3;
        end else begin
            for (int j = 0; j < VIC_N; j++) begin
                if (vic_valid[j] && vic_tag[j] == lt) begin
                    found = j;
                end
            end
            if (found >= 0) begin
                vic_valid[found] = 1'b0;
            end
            // displaced l1 line lands in the slot the counter points at
            if (l1_valid[s]) begin
                vic_tag[vic_ptr]   = l1_tag[s];
                vic_valid[vic_ptr] = 1'b1;
                vic_ptr            = (vic_ptr + 1) % VIC_N;
            end
            l1_valid[s] = 1'b1;
            l1_tag[s]   = lt;
            exp_wait    = (found >= 0) ? 4 : 0;
        end
        exp_miss = (exp_wait == 0);
        if (exp_miss) begin
            exp_mem_count++;
        end
        exp_line = lt;
        exp_word = {addr[ADDR_W-1:2], 2'b00} ^ KEY;
        fetch_count++;
        cpu_addr <= addr;
        cpu_req  <= 1'b1;
        @(posedge clk);
        while (!cpu_ack) begin
            @(posedge clk);
        end
        repeat (hold) @(posedge clk);
        cpu_req <= 1'b0;
        @(posedge clk);
        while (cpu_ack) begin
            @(posedge clk);
        end
    endtask

    initial begin
        apply_reset();
        // all word positions of one line in each of three sets
        for (int s = 1; s <= 3; s++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                fetch(make_addr(tag_t'(20'h00010 + s), set_index_t'(s), word_sel_t'(w)), w % 4);
            end
        end
        // A, B, A, B on one set, the last two hit the victim buffer
        fetch(make_addr(20'h00a01, 6'd5, 4'd3), 0);
        fetch(make_addr(20'h00b02, 6'd5, 4'd7), 2);
        fetch(make_addr(20'h00a01, 6'd5, 4'd9), 1);
        fetch(make_addr(20'h00b02, 6'd5, 4'd1), 3);
        // eighteen lines on one set overflow the victim buffer
        for (int i = 0; i < 18; i++) begin
            fetch(make_addr(tag_t'(20'h00100 + i), 6'd9, word_sel_t'(i)), 0);
        end
        fetch(make_addr(20'h00100, 6'd9, 4'd2), 1);
        fetch(make_addr(20'h00102, 6'd9, 4'd5), 0);
        // contents are gone after a second reset
        apply_reset();
        fetch(make_addr(20'h00011, 6'd1, 4'd4), 2);
        repeat (2) @(posedge clk);
        // one memory transaction per miss, no more
        a_mem_total: assert (mem_count == exp_mem_count)
            else report_mismatch("memory transactions", exp_mem_count, mem_count);
        $display("errors: %0d, memory transactions: %0d, fetches: %0d",
                 err_count, mem_count, fetch_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
icache_pkg.sv
icache_l1_array.sv
victim_icache.sv
icache_ctrl.sv
icache_top.sv
tb_icache_mem.sv
tb_icache.sv
